/* Makefile */
VERILATOR ?= verilator
TOP       := dispatch_tb
FILELIST  := project.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_top (
    input  logic                    clk,
    input  logic                    rst,
    input  isa_pkg::decoded_pack_t  decoded_pack,
    input  logic [3:0]              rs_full,
    input  rename_pkg::cdb_t        cdb,
    output rename_pkg::inst_rs_t    inst_rs,
    output logic [3:0]              rs_load,
    output logic                    stall,
    output rename_pkg::retire_t     retire
);

    logic [isa_pkg::REG_NUM-1:0][isa_pkg::XLEN-1:0]     registers;
    rename_pkg::rob_entry_t [rename_pkg::ROB_SIZE-1:0]  rob;
    logic [rename_pkg::ROB_TAG_LEN-1:0]                 alloc_tag;
    logic                                               rob_full;
    logic                                               dispatch_fire;
    rename_pkg::arch_reg_t                              arch_srcs;
    rename_pkg::renamed_pack_t                          renamed_pack;
    rename_pkg::inst_rob_t                              inst_rob;

    dispatcher u_dispatcher (
        .clk           (clk),
        .rst           (rst),
        .decoded_pack  (decoded_pack),
        .registers     (registers),
        .rob           (rob),
        .alloc_tag     (alloc_tag),
        .rob_full      (rob_full),
        .renamed_pack  (renamed_pack),
        .arch_srcs     (arch_srcs),
        .rs_full       (rs_full),
        .rs_load       (rs_load),
        .stall         (stall),
        .dispatch_fire (dispatch_fire),
        .inst_rs       (inst_rs),
        .inst_rob      (inst_rob)
    );

    map_table u_map_table (
        .clk           (clk),
        .rst           (rst),
        .arch_srcs     (arch_srcs),
        .dispatch_fire (dispatch_fire),
        .alloc_tag     (alloc_tag),
        .cdb           (cdb),
        .retire        (retire),
        .renamed_pack  (renamed_pack)
    );

    // retire feeds the regfile and the map table as well as the port
    reorder_buffer u_reorder_buffer (
        .clk           (clk),
        .rst           (rst),
        .dispatch_fire (dispatch_fire),
        .inst_rob      (inst_rob),
        .cdb           (cdb),
        .alloc_tag     (alloc_tag),
        .rob_full      (rob_full),
        .rob           (rob),
        .retire        (retire)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .retire    (retire),
        .registers (registers)
    );

endmodule

`default_nettype wire

/* design/dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatcher (
    input  logic                                               clk,
    input  logic                                               rst,
    input  isa_pkg::decoded_pack_t                             decoded_pack,
    input  logic [isa_pkg::REG_NUM-1:0][isa_pkg::XLEN-1:0]     registers,
    input  rename_pkg::rob_entry_t [rename_pkg::ROB_SIZE-1:0]  rob,
    input  logic [rename_pkg::ROB_TAG_LEN-1:0]                 alloc_tag,
    input  logic                                               rob_full,
    input  rename_pkg::renamed_pack_t                          renamed_pack,
    output rename_pkg::arch_reg_t                              arch_srcs,
    input  logic [3:0]                                         rs_full,
    output logic [3:0]                                         rs_load,
    output logic                                               stall,
    output logic                                               dispatch_fire,
    output rename_pkg::inst_rs_t                               inst_rs,
    output rename_pkg::inst_rob_t                              inst_rob
);

    logic                 is_branch;
    logic                 use_pc;
    logic                 use_imm;
    rename_pkg::operand_t op1;
    rename_pkg::operand_t op2;

    // pick the operand up from regfile or rob, else leave it pending
    function automatic rename_pkg::operand_t resolve_src(
        input rename_pkg::renamed_src_t                          src,
        input logic [isa_pkg::REG_NUM-1:0][isa_pkg::XLEN-1:0]    regs,
        input rename_pkg::rob_entry_t [rename_pkg::ROB_SIZE-1:0] entries
    );
        rename_pkg::operand_t op;
        op = '0;
        case (src.data_stat)
            rename_pkg::DS_REGFILE: begin
                op.ready = 1'b1;
                op.value = regs[src.reg_addr];
            end
            rename_pkg::DS_ROB: begin
                op.ready = 1'b1;
                op.value = entries[src.rob_tag].wb_data;
            end
            default: begin
                op.ready = 1'b0;
            end
        endcase
        return op;
    endfunction

    assign arch_srcs.src1     = decoded_pack.src1;
    assign arch_srcs.src2     = decoded_pack.src2;
    assign arch_srcs.dest     = decoded_pack.dest;
    assign arch_srcs.has_dest = decoded_pack.has_dest;

    assign is_branch = decoded_pack.fu == isa_pkg::FU_BTU;
    // branches compare registers while pc and imm go along separately
    assign use_pc    = !is_branch && decoded_pack.pc_valid;
    assign use_imm   = !is_branch && decoded_pack.imm_valid;

    assign op1 = resolve_src(renamed_pack.src1, registers, rob);
    assign op2 = resolve_src(renamed_pack.src2, registers, rob);

    always_comb begin
        inst_rs.fu         = decoded_pack.fu;
        inst_rs.func       = decoded_pack.alu_func;
        inst_rs.tag_dest   = alloc_tag;
        inst_rs.tag_src1   = renamed_pack.src1.rob_tag;
        inst_rs.tag_src2   = renamed_pack.src2.rob_tag;
        inst_rs.ready_src1 = op1.ready || use_pc;
        inst_rs.value_src1 = use_pc ? decoded_pack.pc : op1.value;
        inst_rs.ready_src2 = op2.ready || use_imm;
        inst_rs.value_src2 = use_imm ? decoded_pack.imm : op2.value;
        inst_rs.pc         = is_branch ? decoded_pack.pc : '0;
        inst_rs.imm        = is_branch ? decoded_pack.imm : '0;
    end

    // one station per unit indexed by fu
    always_comb begin
        rs_load = '0;
        rs_load[decoded_pack.fu] = decoded_pack.valid && !rs_full[decoded_pack.fu] && !rob_full;
    end

    assign stall         = decoded_pack.valid && (rs_full[decoded_pack.fu] || rob_full);
    assign dispatch_fire = |rs_load;

    assign inst_rob.dest     = decoded_pack.dest;
    assign inst_rob.has_dest = decoded_pack.has_dest;
    assign inst_rob.inst_pc  = decoded_pack.pc;
    assign inst_rob.inst_npc = decoded_pack.pc + 32'd4;

    // the rob slot behind the new tag has to be free
    alloc_slot_free: assert property (
        @(posedge clk) disable iff (rst) dispatch_fire |-> !rob[alloc_tag].busy
    );

    // upstream must hold the packet while we stall
    hold_on_stall: assert property (
        @(posedge clk) disable iff (rst) stall |=> $stable(decoded_pack)
    );

endmodule

`default_nettype wire

/* design/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int XLEN         = 32;
    localparam int REG_ADDR_LEN = 5;
    localparam int REG_NUM      = 32;

    // value doubles as the reservation station index
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_LSU  = 2'd1,
        FU_MULT = 2'd2,
        FU_BTU  = 2'd3
    } fu_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_MUL  = 4'd10,
        ALU_MULH = 4'd11,
        ALU_BEQ  = 4'd12,
        ALU_BNE  = 4'd13,
        ALU_BLT  = 4'd14,
        ALU_BGE  = 4'd15
    } alu_func_e;

    typedef struct packed {
        logic                    valid;
        fu_e                     fu;
        alu_func_e               alu_func;
        logic [REG_ADDR_LEN-1:0] dest;
        logic [REG_ADDR_LEN-1:0] src1;
        logic [REG_ADDR_LEN-1:0] src2;
        logic                    has_dest;
        logic [XLEN-1:0]         pc;
        logic [XLEN-1:0]         imm;
        // src1 is the pc
        logic                    pc_valid;
        // src2 is the immediate
        logic                    imm_valid;
    } decoded_pack_t;

endpackage

`default_nettype wire

/* design/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

module map_table (
    input  logic                                  clk,
    input  logic                                  rst,
    input  rename_pkg::arch_reg_t                 arch_srcs,
    input  logic                                  dispatch_fire,
    input  logic [rename_pkg::ROB_TAG_LEN-1:0]    alloc_tag,
    input  rename_pkg::cdb_t                      cdb,
    input  rename_pkg::retire_t                   retire,
    output rename_pkg::renamed_pack_t             renamed_pack
);

    rename_pkg::map_entry_t [isa_pkg::REG_NUM-1:0] map_q;

    // status of one source, no bypass from a cdb in flight
    function automatic rename_pkg::renamed_src_t lookup(
        input logic [isa_pkg::REG_ADDR_LEN-1:0] addr,
        input rename_pkg::map_entry_t           entry
    );
        rename_pkg::renamed_src_t src;
        src.reg_addr = addr;
        src.rob_tag  = entry.rob_tag;
        if (!entry.busy) begin
            src.data_stat = rename_pkg::DS_REGFILE;
        end else if (entry.ready) begin
            src.data_stat = rename_pkg::DS_ROB;
        end else begin
            src.data_stat = rename_pkg::DS_PENDING;
        end
        return src;
    endfunction

    assign renamed_pack.src1 = lookup(arch_srcs.src1, map_q[arch_srcs.src1]);
    assign renamed_pack.src2 = lookup(arch_srcs.src2, map_q[arch_srcs.src2]);

    // x0 is left out of the loop so it stays in the register file
    always_ff @(posedge clk) begin
        if (rst) begin
            map_q <= '0;
        end else begin
            for (int i = 1; i < isa_pkg::REG_NUM; i++) begin
                // release only if no newer writer took the register
                if (retire.valid && retire.has_dest &&
                    retire.dest == isa_pkg::REG_ADDR_LEN'(i) &&
                    map_q[i].busy && map_q[i].rob_tag == retire.tag) begin
                    map_q[i].busy  <= 1'b0;
                    map_q[i].ready <= 1'b0;
                end
                if (cdb.valid && map_q[i].busy && map_q[i].rob_tag == cdb.tag) begin
                    map_q[i].ready <= 1'b1;
                end
                // new rename wins over release and ready
                if (dispatch_fire && arch_srcs.has_dest &&
                    arch_srcs.dest == isa_pkg::REG_ADDR_LEN'(i)) begin
                    map_q[i].busy    <= 1'b1;
                    map_q[i].ready   <= 1'b0;
                    map_q[i].rob_tag <= alloc_tag;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                                            clk,
    input  logic                                            rst,
    input  rename_pkg::retire_t                             retire,
    output logic [isa_pkg::REG_NUM-1:0][isa_pkg::XLEN-1:0]  registers
);

    logic wr_en;

    // x0 never written, so it keeps its reset value
    assign wr_en = retire.valid && retire.has_dest && retire.dest != '0;

    // read side is the array itself
    always_ff @(posedge clk) begin
        if (rst) begin
            registers <= '0;
        end else if (wr_en) begin
            registers[retire.dest] <= retire.data;
        end
    end

endmodule

`default_nettype wire

/* design/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    localparam int ROB_TAG_LEN = 4;
    localparam int ROB_SIZE    = 16;

    // where a source operand currently lives
    typedef enum logic [1:0] {
        DS_REGFILE = 2'b00,
        DS_PENDING = 2'b01,
        DS_ROB     = 2'b11
    } data_stat_e;

    typedef struct packed {
        logic                   busy;
        logic                   ready;
        logic [ROB_TAG_LEN-1:0] rob_tag;
    } map_entry_t;

    // architectural addresses handed to the map table
    typedef struct packed {
        logic [isa_pkg::REG_ADDR_LEN-1:0] src1;
        logic [isa_pkg::REG_ADDR_LEN-1:0] src2;
        logic [isa_pkg::REG_ADDR_LEN-1:0] dest;
        logic                             has_dest;
    } arch_reg_t;

    typedef struct packed {
        logic [isa_pkg::REG_ADDR_LEN-1:0] reg_addr;
        logic [ROB_TAG_LEN-1:0]           rob_tag;
        data_stat_e                       data_stat;
    } renamed_src_t;

    typedef struct packed {
        renamed_src_t src1;
        renamed_src_t src2;
    } renamed_pack_t;

    typedef struct packed {
        logic                     ready;
        logic [isa_pkg::XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        isa_pkg::fu_e             fu;
        isa_pkg::alu_func_e       func;
        logic [ROB_TAG_LEN-1:0]   tag_dest;
        logic [ROB_TAG_LEN-1:0]   tag_src1;
        logic [ROB_TAG_LEN-1:0]   tag_src2;
        logic                     ready_src1;
        logic                     ready_src2;
        logic [isa_pkg::XLEN-1:0] value_src1;
        logic [isa_pkg::XLEN-1:0] value_src2;
        logic [isa_pkg::XLEN-1:0] imm;
        logic [isa_pkg::XLEN-1:0] pc;
    } inst_rs_t;

    typedef struct packed {
        logic [isa_pkg::REG_ADDR_LEN-1:0] dest;
        logic                             has_dest;
        logic [isa_pkg::XLEN-1:0]         inst_pc;
        logic [isa_pkg::XLEN-1:0]         inst_npc;
    } inst_rob_t;

    typedef struct packed {
        logic                             busy;
        logic                             done;
        logic [isa_pkg::REG_ADDR_LEN-1:0] dest;
        logic                             has_dest;
        logic [isa_pkg::XLEN-1:0]         wb_data;
    } rob_entry_t;

    typedef struct packed {
        logic                     valid;
        logic [ROB_TAG_LEN-1:0]   tag;
        logic [isa_pkg::XLEN-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic                             valid;
        logic [ROB_TAG_LEN-1:0]           tag;
        logic [isa_pkg::REG_ADDR_LEN-1:0] dest;
        logic                             has_dest;
        logic [isa_pkg::XLEN-1:0]         data;
    } retire_t;

endpackage

`default_nettype wire

/* design/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               dispatch_fire,
    input  rename_pkg::inst_rob_t                              inst_rob,
    input  rename_pkg::cdb_t                                   cdb,
    output logic [rename_pkg::ROB_TAG_LEN-1:0]                 alloc_tag,
    output logic                                               rob_full,
    output rename_pkg::rob_entry_t [rename_pkg::ROB_SIZE-1:0]  rob,
    output rename_pkg::retire_t                                retire
);

    localparam int TW = rename_pkg::ROB_TAG_LEN;

    logic [TW-1:0] head;
    logic [TW-1:0] tail;
    logic [TW:0]   count;

    logic [rename_pkg::ROB_SIZE-1:0]  busy_q;
    logic [rename_pkg::ROB_SIZE-1:0]  done_q;
    logic [rename_pkg::ROB_SIZE-1:0]  has_dest_q;
    logic [isa_pkg::REG_ADDR_LEN-1:0] dest_q [rename_pkg::ROB_SIZE];
    logic [isa_pkg::XLEN-1:0]         data_q [rename_pkg::ROB_SIZE];

    logic retire_fire;

    assign alloc_tag   = tail;
    assign rob_full    = count == (TW + 1)'(rename_pkg::ROB_SIZE);
    assign retire_fire = busy_q[head] & done_q[head];

    // whole array goes to the dispatcher for rob-ready operands
    always_comb begin
        for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
            rob[i].busy     = busy_q[i];
            rob[i].done     = done_q[i];
            rob[i].dest     = dest_q[i];
            rob[i].has_dest = has_dest_q[i];
            rob[i].wb_data  = data_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            busy_q <= '0;
            done_q <= '0;
        end else begin
            if (dispatch_fire) begin
                busy_q[tail] <= 1'b1;
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done_q[cdb.tag] <= 1'b1;
            end
            if (retire_fire) begin
                busy_q[head] <= 1'b0;
                done_q[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            count <= count + {{TW{1'b0}}, dispatch_fire} - {{TW{1'b0}}, retire_fire};
        end
    end

    // wb_data stays after retire, readers still see it until the regfile write
    always_ff @(posedge clk) begin
        if (dispatch_fire) begin
            dest_q[tail]     <= inst_rob.dest;
            has_dest_q[tail] <= inst_rob.has_dest;
        end
        if (cdb.valid) begin
            data_q[cdb.tag] <= cdb.data;
        end
    end

    always_ff @(posedge clk) begin
        retire.tag      <= head;
        retire.dest     <= dest_q[head];
        retire.has_dest <= has_dest_q[head];
        retire.data     <= data_q[head];
        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= retire_fire;
        end
    end

    // dispatcher has to respect rob_full
    no_alloc_when_full: assert property (
        @(posedge clk) disable iff (rst) dispatch_fire |-> !rob_full
    );

    // one result per tag, and only for an instruction still in flight
    cdb_to_live_entry: assert property (
        @(posedge clk) disable iff (rst) cdb.valid |-> busy_q[cdb.tag] && !done_q[cdb.tag]
    );

endmodule

`default_nettype wire

/* dv/dispatch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_tb;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS  = 6;

    logic                   clk;
    logic                   rst;
    isa_pkg::decoded_pack_t decoded_pack;
    logic [3:0]             rs_full;
    rename_pkg::cdb_t       cdb;
    rename_pkg::inst_rs_t   inst_rs;
    logic [3:0]             rs_load;
    logic                   stall;
    rename_pkg::retire_t    retire;

    // reference model state
    logic [3:0]             next_tag;
    logic [31:0]            shadow_regs [32];
    logic [31:0]            rob_data [16];
    logic                   done_model [16];
    logic                   pend_busy [32];
    logic                   pend_ready [32];
    logic [3:0]             pend_tag [32];
    rename_pkg::retire_t    inflight_q [$];
    rename_pkg::retire_t    retired_q [$];
    rename_pkg::inst_rs_t   last_rs;

    string                  test_name;
    int                     errors;
    int                     checks;
    int                     errors_at_start;

    dispatch_top UUT (
        .clk          (clk),
        .rst          (rst),
        .decoded_pack (decoded_pack),
        .rs_full      (rs_full),
        .cdb          (cdb),
        .inst_rs      (inst_rs),
        .rs_load      (rs_load),
        .stall        (stall),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 200 cycles per test is far more than any test needs
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles in test %s", NUM_TESTS * 200, test_name);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // retirements in the order the DUT produced them
    always @(posedge clk) begin
        if (retire.valid === 1'b1) begin
            retired_q.push_back(retire);
        end
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    function automatic isa_pkg::decoded_pack_t make_inst(
        input isa_pkg::fu_e fu,
        input logic [4:0]   dest,
        input logic [4:0]   src1,
        input logic [4:0]   src2,
        input logic         has_dest,
        input logic         pc_valid,
        input logic         imm_valid
    );
        isa_pkg::decoded_pack_t p;
        p           = '0;
        p.valid     = 1'b1;
        p.fu        = fu;
        p.alu_func  = isa_pkg::alu_func_e'(4'($urandom));
        p.dest      = dest;
        p.src1      = src1;
        p.src2      = src2;
        p.has_dest  = has_dest;
        p.pc        = $urandom;
        p.imm       = $urandom;
        p.pc_valid  = pc_valid;
        p.imm_valid = imm_valid;
        return p;
    endfunction

    // regfile when idle, rob data once the result is out, else the tag
    function automatic void expect_src(
        input  logic [4:0]  addr,
        output logic        rdy,
        output logic [31:0] val,
        output logic [3:0]  tag
    );
        tag = pend_tag[addr];
        val = '0;
        rdy = 1'b1;
        if (!pend_busy[addr]) begin
            val = shadow_regs[addr];
        end else if (pend_ready[addr]) begin
            val = rob_data[pend_tag[addr]];
        end else begin
            rdy = 1'b0;
        end
    endfunction

    task automatic dispatch_inst(input isa_pkg::decoded_pack_t pack, input logic [3:0] full);
        logic                is_br;
        logic                rdy1;
        logic                rdy2;
        logic [31:0]         val1;
        logic [31:0]         val2;
        logic [3:0]          tag1;
        logic [3:0]          tag2;
        rename_pkg::retire_t ent;
        is_br = pack.fu == isa_pkg::FU_BTU;
        expect_src(pack.src1, rdy1, val1, tag1);
        expect_src(pack.src2, rdy2, val2, tag2);
        if (!is_br && pack.pc_valid) begin
            rdy1 = 1'b1;
            val1 = pack.pc;
        end
        if (!is_br && pack.imm_valid) begin
            rdy2 = 1'b1;
            val2 = pack.imm;
        end
        @(negedge clk);
        decoded_pack = pack;
        rs_full      = full;
        #1;
        check_val("stall", 32'd0, 32'(stall));
        check_val("rs_load", 32'(4'b0001 << pack.fu), 32'(rs_load));
        check_val("fu", 32'(pack.fu), 32'(inst_rs.fu));
        check_val("func", 32'(pack.alu_func), 32'(inst_rs.func));
        check_val("tag_dest", 32'(next_tag), 32'(inst_rs.tag_dest));
        check_val("ready_src1", 32'(rdy1), 32'(inst_rs.ready_src1));
        check_val("ready_src2", 32'(rdy2), 32'(inst_rs.ready_src2));
        if (rdy1) check_val("value_src1", val1, inst_rs.value_src1);
        else check_val("tag_src1", 32'(tag1), 32'(inst_rs.tag_src1));
        if (rdy2) check_val("value_src2", val2, inst_rs.value_src2);
        else check_val("tag_src2", 32'(tag2), 32'(inst_rs.tag_src2));
        check_val("pc", is_br ? pack.pc : 32'd0, inst_rs.pc);
        check_val("imm", is_br ? pack.imm : 32'd0, inst_rs.imm);
        last_rs = inst_rs;
        ent          = '0;
        ent.tag      = next_tag;
        ent.dest     = pack.dest;
        ent.has_dest = pack.has_dest;
        inflight_q.push_back(ent);
        done_model[next_tag] = 1'b0;
        // x0 keeps its regfile mapping
        if (pack.has_dest && pack.dest != 5'd0) begin
            pend_busy[pack.dest]  = 1'b1;
            pend_ready[pack.dest] = 1'b0;
            pend_tag[pack.dest]   = next_tag;
        end
        next_tag = next_tag + 4'd1;
        @(negedge clk);
        decoded_pack = '0;
        rs_full      = '0;
    endtask

    task automatic send_cdb(input logic [3:0] tag, input logic [31:0] data);
        @(negedge clk);
        cdb.valid = 1'b1;
        cdb.tag   = tag;
        cdb.data  = data;
        rob_data[tag]   = data;
        done_model[tag] = 1'b1;
        for (int r = 1; r < 32; r++) begin
            if (pend_busy[r] && pend_tag[r] == tag) pend_ready[r] = 1'b1;
        end
        @(negedge clk);
        cdb = '0;
    endtask

    // oldest in-flight instruction must be the next one out
    task automatic wait_retire();
        rename_pkg::retire_t exp;
        rename_pkg::retire_t got;
        int                  waited;
        exp    = inflight_q.pop_front();
        waited = 0;
        while (retired_q.size() == 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (retired_q.size() != 0) else begin
            $display("%s: tag %0d was never retired", test_name, exp.tag);
            errors++;
        end
        if (retired_q.size() != 0) begin
            got = retired_q.pop_front();
            check_val("retire_tag", 32'(exp.tag), 32'(got.tag));
            check_val("retire_dest", 32'(exp.dest), 32'(got.dest));
            check_val("retire_has_dest", 32'(exp.has_dest), 32'(got.has_dest));
            check_val("retire_data", rob_data[exp.tag], got.data);
        end
        if (exp.has_dest && exp.dest != 5'd0) shadow_regs[exp.dest] = rob_data[exp.tag];
        if (exp.has_dest && pend_busy[exp.dest] && pend_tag[exp.dest] == exp.tag) begin
            pend_busy[exp.dest]  = 1'b0;
            pend_ready[exp.dest] = 1'b0;
        end
    endtask

    // stands in for the functional units with results in program order
    task automatic complete_all();
        for (int i = 0; i < inflight_q.size(); i++) begin
            if (!done_model[inflight_q[i].tag]) send_cdb(inflight_q[i].tag, $urandom);
        end
        while (inflight_q.size() != 0) wait_retire();
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        $display("%s: %s, %0d errors", test_name,
                 (errors == errors_at_start) ? "ok" : "failed", errors - errors_at_start);
    endtask

    task automatic reset_values();
        start_test("reset");
        @(negedge clk);
        #1;
        check_val("rs_load", 32'd0, 32'(rs_load));
        check_val("retire_valid", 32'd0, 32'(retire.valid));
        // full stations alone must not stall an empty slot
        @(negedge clk);
        rs_full = 4'b1111;
        #1;
        check_val("stall", 32'd0, 32'(stall));
        dispatch_inst(make_inst(isa_pkg::FU_ALU, 5'd1, 5'd2, 5'd3, 1'b1, 1'b0, 1'b0), 4'b0000);
        check_val("first_tag", 32'd0, 32'(last_rs.tag_dest));
        complete_all();
        end_test();
    endtask

    task automatic regfile_path();
        logic [3:0] wr_tag;
        start_test("regfile_path");
        dispatch_inst(make_inst(isa_pkg::FU_ALU, 5'd5, 5'd1, 5'd2, 1'b1, 1'b0, 1'b0), 4'b0000);
        wr_tag = last_rs.tag_dest;
        send_cdb(wr_tag, 32'hc0de_0005);
        wait_retire();
        dispatch_inst(make_inst(isa_pkg::FU_ALU, 5'd6, 5'd5, 5'd0, 1'b1, 1'b0, 1'b0), 4'b0000);
        check_val("x5_ready", 32'd1, 32'(last_rs.ready_src1));
        check_val("x5_value", 32'hc0de_0005, last_rs.value_src1);
        complete_all();
        end_test();
    endtask

    task automatic dependency_renaming();
        logic [3:0] blocker;
        logic [3:0] w1;
        logic [3:0] w2;
        start_test("dependency");
        // undone branch at the head keeps the writer from retiring
        dispatch_inst(make_inst(isa_pkg::FU_BTU, 5'd0, 5'd1, 5'd2, 1'b0, 1'b0, 1'b0), 4'b0000);
        blocker = last_rs.tag_dest;
        dispatch_inst(make_inst(isa_pkg::FU_ALU, 5'd7, 5'd1, 5'd2, 1'b1, 1'b0, 1'b0), 4'b0000);
        w1 = last_rs.tag_dest;
        dispatch_inst(make_inst(isa_pkg::FU_ALU, 5'd8, 5'd7, 5'd0, 1'b1, 1'b0, 1'b0), 4'b0000);
        check_val("early_ready", 32'd0, 32'(last_rs.ready_src1));
        check_val("early_tag", 32'(w1), 32'(last_rs.tag_src1));
        send_cdb(w1, 32'h7777_0001);
        dispatch_inst(make_inst(isa_pkg::FU_ALU, 5'd9, 5'd7, 5'd0, 1'b1, 1'b0, 1'b0), 4'b0000);
        check_val("rob_ready", 32'd1, 32'(last_rs.ready_src1));
        check_val("rob_value", 32'h7777_0001, last_rs.value_src1);
        dispatch_inst(make_inst(isa_pkg::FU_MULT, 5'd7, 5'd2, 5'd3, 1'b1, 1'b0, 1'b0), 4'b0000);
        w2 = last_rs.tag_dest;
        send_cdb(blocker, $urandom);
        wait_retire();
        wait_retire();
        // x7 must still point at the newer writer
        dispatch_inst(make_inst(isa_pkg::FU_ALU, 5'd10, 5'd7, 5'd0, 1'b1, 1'b0, 1'b0), 4'b0000);
        check_val("newer_ready", 32'd0, 32'(last_rs.ready_src1));
        check_val("newer_tag", 32'(w2), 32'(last_rs.tag_src1));
        complete_all();
        end_test();
    endtask

    task automatic operand_overrides();
        isa_pkg::decoded_pack_t p;
        start_test("overrides");
        p = make_inst(isa_pkg::FU_ALU, 5'd11, 5'd5, 5'd6, 1'b1, 1'b1, 1'b1);
        dispatch_inst(p, 4'b0000);
        check_val("alu_src1_pc", p.pc, last_rs.value_src1);
        check_val("alu_src2_imm", p.imm, last_rs.value_src2);
        p = make_inst(isa_pkg::FU_BTU, 5'd0, 5'd5, 5'd1, 1'b0, 1'b1, 1'b1);
        dispatch_inst(p, 4'b0000);
        check_val("branch_src1", shadow_regs[5], last_rs.value_src1);
        dispatch_inst(make_inst(isa_pkg::FU_LSU, 5'd12, 5'd1, 5'd0, 1'b1, 1'b0, 1'b1), 4'b0000);
        dispatch_inst(make_inst(isa_pkg::FU_MULT, 5'd13, 5'd5, 5'd6, 1'b1, 1'b0, 1'b0), 4'b0000);
        complete_all();
        end_test();
    endtask

    task automatic backpressure();
        isa_pkg::decoded_pack_t p;
        isa_pkg::fu_e           fu;
        logic [3:0]             full;
        start_test("backpressure");
        for (int i = 0; i < 8; i++) begin
            fu   = isa_pkg::fu_e'(2'($urandom));
            full = 4'($urandom);
            p    = make_inst(fu, 5'(12 + i % 4), 5'($urandom), 5'($urandom), 1'b1, 1'b0, 1'b0);
            if (full[fu]) begin
                @(negedge clk);
                decoded_pack = p;
                rs_full      = full;
                #1;
                check_val("stall", 32'd1, 32'(stall));
                check_val("rs_load", 32'd0, 32'(rs_load));
                check_val("held_tag", 32'(next_tag), 32'(inst_rs.tag_dest));
                full[fu] = 1'b0;
            end
            dispatch_inst(p, full);
        end
        complete_all();
        end_test();
    endtask

    task automatic rob_full_stall();
        isa_pkg::decoded_pack_t p;
        logic [3:0]             head_tag;
        start_test("rob_full");
        for (int i = 0; i < 16; i++) begin
            p = make_inst(isa_pkg::FU_ALU, 5'(16 + i % 8), 5'(16 + (i + 7) % 8), 5'd1,
                          1'b1, 1'b0, 1'b0);
            dispatch_inst(p, 4'b0000);
        end
        head_tag = inflight_q[0].tag;
        p = make_inst(isa_pkg::FU_LSU, 5'd24, 5'd16, 5'd0, 1'b1, 1'b0, 1'b1);
        @(negedge clk);
        decoded_pack = p;
        #1;
        check_val("full_stall", 32'd1, 32'(stall));
        check_val("full_rs_load", 32'd0, 32'(rs_load));
        send_cdb(head_tag, $urandom);
        dispatch_inst(p, 4'b0000);
        check_val("reused_tag", 32'(head_tag), 32'(last_rs.tag_dest));
        wait_retire();
        complete_all();
        end_test();
    endtask

    initial begin
        void'($urandom(32'ha6fa9ec4));
        errors    = 0;
        checks    = 0;
        test_name = "init";
        next_tag  = '0;
        for (int r = 0; r < 32; r++) begin
            shadow_regs[r] = '0;
            pend_busy[r]   = 1'b0;
            pend_ready[r]  = 1'b0;
            pend_tag[r]    = '0;
        end
        for (int t = 0; t < 16; t++) begin
            rob_data[t]   = '0;
            done_model[t] = 1'b0;
        end
        rst          = 1'b1;
        decoded_pack = '0;
        rs_full      = '0;
        cdb          = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        reset_values();
        regfile_path();
        dependency_renaming();
        operand_overrides();
        backpressure();
        rob_full_stall();

        $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/isa_pkg.sv
design/rename_pkg.sv
design/map_table.sv
design/reorder_buffer.sv
design/regfile.sv
design/dispatcher.sv
design/dispatch_top.sv
dv/dispatch_tb.sv
